// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int MEM_AW = 8; // 256 words

    // Major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_ARITH  = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_ECALL  = 7'b1110011;

    // funct3 of the R-type operations
    // Sub is add with funct7[5] set
    localparam logic [2:0] ALU_F3_ADD = 3'b000;
    localparam logic [2:0] ALU_F3_SLT = 3'b010;
    localparam logic [2:0] ALU_F3_OR  = 3'b110;
    localparam logic [2:0] ALU_F3_AND = 3'b111;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_FUNCT = 2'b10
    } alu_op_t;

    typedef enum logic [3:0] {
        INST_FETCH            = 4'd0,
        INST_DECODE_REG_FETCH = 4'd1,
        MEM_ADDR_COMPUTATION  = 4'd2,
        MEM_ACCESS_READ       = 4'd3,
        WB_STEP               = 4'd4,
        MEM_ACCESS_WRITE      = 4'd5,
        EXECUTION             = 4'd6,
        R_TYPE_COMPLETION     = 4'd7,
        BRANCH_COMPLETION     = 4'd8,
        HALT                  = 4'd9
    } cu_state_t;

    typedef struct packed {
        logic       pc_write_cond;
        logic       pc_write;
        logic       i_or_d;     // 1 selects ALUOut as memory address
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       ir_write;
        logic       pc_source;  // 1 selects ALUOut as next PC
        logic       reg_write;
        logic       halted;
        alu_op_t    alu_op;
        logic       alu_src_a;  // 1 selects A
        logic [1:0] alu_src_b;  // 00 B, 01 four, 10 immediate
    } ctrl_t;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_t alu_op,
    input  logic [2:0]      funct3,
    input  logic            funct7_5,
    output logic [31:0]     result,
    output logic            zero
);
    import rv_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_SUB: result = a - b;
            ALU_FUNCT: begin
                case (funct3)
                    ALU_F3_ADD: result = funct7_5 ? (a - b) : (a + b);
                    ALU_F3_AND: result = a & b;
                    ALU_F3_OR:  result = a | b;
                    ALU_F3_SLT: result = {31'd0, $signed(a) < $signed(b)};
                    default:    result = a + b;
                endcase
            end
            default: result = a + b; // Address and PC arithmetic
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [4:0]  dbg_addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    output logic [31:0] dbg_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 always reads zero whatever the array holds
    assign rdata1   = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2   = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
    assign dbg_data = (dbg_addr == 5'd0) ? 32'd0 : regs[dbg_addr];

endmodule

// ==== hdl/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory (
    input  logic                      clk,
    input  logic                      reset,
    input  rv_pkg::ctrl_t             ctrl,
    input  logic [31:0]               addr,
    input  logic [31:0]               wdata,
    output logic [31:0]               rdata,
    input  logic                      load_en,
    input  logic [rv_pkg::MEM_AW-1:0] load_addr,
    input  logic [31:0]               load_data,
    input  logic [rv_pkg::MEM_AW-1:0] dbg_addr,
    output logic [31:0]               dbg_data
);
    import rv_pkg::*;

    logic [31:0]       mem [2**MEM_AW];
    logic [MEM_AW-1:0] word_addr;

    assign word_addr = addr[MEM_AW+1:2]; // Byte address to word index

    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_en) begin
                mem[load_addr] <= load_data; // Program load
            end
        end else if (ctrl.mem_write) begin
            mem[word_addr] <= wdata;
        end
    end

    assign rdata    = mem[word_addr];
    assign dbg_data = mem[dbg_addr];

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic [6:0]    opcode,
    output rv_pkg::ctrl_t ctrl
);
    import rv_pkg::*;

    cu_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= INST_FETCH;
        end else begin
            case (state)
                INST_FETCH: state <= INST_DECODE_REG_FETCH;
                INST_DECODE_REG_FETCH: begin
                    case (opcode)
                        OPC_LOAD, OPC_STORE: state <= MEM_ADDR_COMPUTATION;
                        OPC_ARITH:           state <= EXECUTION;
                        OPC_BRANCH:          state <= BRANCH_COMPLETION;
                        OPC_ECALL:           state <= HALT;
                        default:             state <= INST_FETCH; // Unknown opcode
                    endcase
                end
                MEM_ADDR_COMPUTATION: begin
                    if (opcode == OPC_STORE) begin
                        state <= MEM_ACCESS_WRITE;
                    end else begin
                        state <= MEM_ACCESS_READ;
                    end
                end
                MEM_ACCESS_READ:   state <= WB_STEP;
                WB_STEP:           state <= INST_FETCH;
                MEM_ACCESS_WRITE:  state <= INST_FETCH;
                EXECUTION:         state <= R_TYPE_COMPLETION;
                R_TYPE_COMPLETION: state <= INST_FETCH;
                BRANCH_COMPLETION: state <= INST_FETCH;
                HALT:              state <= HALT; // Left only by reset
                default:           state <= INST_FETCH;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            INST_FETCH: begin
                ctrl.mem_read  = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.alu_src_b = 2'b01;
                ctrl.pc_write  = 1'b1;
            end
            INST_DECODE_REG_FETCH: begin
                ctrl.alu_src_b = 2'b10; // Branch target into ALUOut
            end
            MEM_ADDR_COMPUTATION: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 2'b10;
            end
            MEM_ACCESS_READ: begin
                ctrl.mem_read = 1'b1;
                ctrl.i_or_d   = 1'b1;
            end
            WB_STEP: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            MEM_ACCESS_WRITE: begin
                ctrl.mem_write = 1'b1;
                ctrl.i_or_d    = 1'b1;
            end
            EXECUTION: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_op    = ALU_FUNCT;
            end
            R_TYPE_COMPLETION: ctrl.reg_write = 1'b1;
            BRANCH_COMPLETION: begin
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_op        = ALU_SUB;
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source     = 1'b1;
            end
            HALT: ctrl.halted = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::ctrl_t ctrl,
    output logic [6:0]    opcode,
    output logic [31:0]   mem_addr,
    output logic [31:0]   mem_wdata,
    input  logic [31:0]   mem_rdata,
    input  logic [4:0]    dbg_reg_addr,
    output logic [31:0]   dbg_reg_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_of_ir; // Address of the instruction in IR
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] mdr;
    logic [XLEN-1:0] a_reg;
    logic [XLEN-1:0] b_reg;
    logic [XLEN-1:0] alu_out;

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] reg_wdata;
    logic            zero;

    assign opcode = ir[6:0];

    always_comb begin
        case (opcode)
            OPC_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            default:    imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    // Fetch adds to PC and decode to the address of the fetched instruction
    always_comb begin
        if (ctrl.alu_src_a) begin
            src_a = a_reg;
        end else if (ctrl.ir_write) begin
            src_a = pc;
        end else begin
            src_a = pc_of_ir;
        end
    end

    always_comb begin
        case (ctrl.alu_src_b)
            2'b00:   src_b = b_reg;
            2'b01:   src_b = 32'd4;
            default: src_b = imm;
        endcase
    end

    assign pc_next   = ctrl.pc_source ? alu_out : alu_result;
    assign mem_addr  = ctrl.i_or_d ? alu_out : pc;
    assign mem_wdata = b_reg;
    assign reg_wdata = ctrl.mem_to_reg ? mdr : alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (ctrl.pc_write || (ctrl.pc_write_cond && zero)) begin
                pc <= pc_next;
            end
            if (ctrl.ir_write) begin
                ir <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            pc_of_ir <= pc;
        end
        if (ctrl.mem_read) begin
            mdr <= mem_rdata;
        end
        a_reg   <= rdata1;
        b_reg   <= rdata2;
        alu_out <= alu_result;
    end

    register_file i_register_file (
        .clk      (clk),
        .we       (ctrl.reg_write),
        .rs1      (ir[19:15]),
        .rs2      (ir[24:20]),
        .rd       (ir[11:7]),
        .dbg_addr (dbg_reg_addr),
        .wdata    (reg_wdata),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .dbg_data (dbg_reg_data)
    );

    alu i_alu (
        .a        (src_a),
        .b        (src_b),
        .alu_op   (ctrl.alu_op),
        .funct3   (ir[14:12]),
        .funct7_5 (ir[30]),
        .result   (alu_result),
        .zero     (zero)
    );

endmodule

// ==== hdl/multicycle_cpu.sv ====
`timescale 1ns/1ps

module multicycle_cpu (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load_en,
    input  logic [rv_pkg::MEM_AW-1:0] load_addr,
    input  logic [rv_pkg::XLEN-1:0]   load_data,
    input  logic [rv_pkg::MEM_AW-1:0] dbg_mem_addr,
    output logic [rv_pkg::XLEN-1:0]   dbg_mem_data,
    input  logic [4:0]                dbg_reg_addr,
    output logic [rv_pkg::XLEN-1:0]   dbg_reg_data,
    output logic                      halted
);
    import rv_pkg::*;

    ctrl_t           ctrl;
    logic [6:0]      opcode;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;

    assign halted = ctrl.halted;

    control_unit i_control_unit (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    datapath i_datapath (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .opcode       (opcode),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    unified_memory i_unified_memory (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_mem_addr),
        .dbg_data  (dbg_mem_data)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic hold,  // Keeps reset high during program load
    output logic clk,
    output logic reset
);
    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 4;

    int unsigned count = 0;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset lasts RESET_CYCLES edges after hold drops
    always @(posedge clk) begin
        if (hold) begin
            count <= 0;
        end else if (count < RESET_CYCLES) begin
            count <= count + 1;
        end
    end

    assign reset = hold || (count < RESET_CYCLES);

endmodule

// ==== sim/tb_multicycle_cpu.sv ====
`timescale 1ns/1ps

module tb_multicycle_cpu;
    import rv_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 14;       // Six directed tests plus eight random rounds
    localparam int CYCLES_PER_TEST = 2000;
    localparam int WAIT_LIMIT = 1000;
    localparam logic [31:0] LFSR_SEED = 32'd57;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int CYC_LW = 5;
    localparam int CYC_SW = 4;
    localparam int CYC_R = 4;
    localparam int CYC_BEQ = 3;
    localparam int CYC_ECALL = 2;

    logic clk;
    logic reset;
    logic hold;
    logic load_en;
    logic [MEM_AW-1:0] load_addr;
    logic [XLEN-1:0] load_data;
    logic [MEM_AW-1:0] dbg_mem_addr;
    logic [XLEN-1:0] dbg_mem_data;
    logic [4:0] dbg_reg_addr;
    logic [XLEN-1:0] dbg_reg_data;
    logic halted;

    logic [31:0] lfsr;
    logic [XLEN-1:0] program_q[$];
    int data_addr_q[$];                  // Byte addresses
    logic [XLEN-1:0] data_val_q[$];

    tb_clock_gen i_tb_clock_gen (.hold(hold), .clk(clk), .reset(reset));

    multicycle_cpu i_multicycle_cpu (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .dbg_mem_addr (dbg_mem_addr),
        .dbg_mem_data (dbg_mem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .halted       (halted)
    );

    function automatic logic [31:0] r_type_instr(input logic [2:0] f3, input logic sub,
                                                 input int rd, input int rs1, input int rs2);
        return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_ARITH};
    endfunction

    function automatic logic [31:0] load_word_instr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
    endfunction

    function automatic logic [31:0] store_word_instr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_eq_instr(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] ecall_instr();
        return {25'd0, OPC_ECALL};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < XLEN; i++) begin
            w = {w[XLEN-2:0], lfsr[0]}; // One step per bit
            lfsr = lfsr_step(lfsr);
        end
        return w;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0d cycles, actual %0d cycles",
                                name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input int idx, input logic [XLEN-1:0] expected);
        @(posedge clk);
        #10;
        dbg_reg_addr = idx[4:0];
        @(negedge clk);
        check_word($sformatf("%s x%0d", name, idx), expected, dbg_reg_data);
    endtask

    task automatic check_mem(input string name, input int byte_addr,
                             input logic [XLEN-1:0] expected);
        @(posedge clk);
        #10;
        dbg_mem_addr = MEM_AW'(byte_addr >> 2);
        @(negedge clk);
        check_word($sformatf("%s mem[0x%0h]", name, byte_addr), expected, dbg_mem_data);
    endtask

    task automatic clear_image();
        program_q.delete();
        data_addr_q.delete();
        data_val_q.delete();
    endtask

    task automatic place_data(input int byte_addr, input logic [XLEN-1:0] value);
        data_addr_q.push_back(byte_addr);
        data_val_q.push_back(value);
    endtask

    // Load the image under reset, release it and count cycles until halted
    task automatic run_program(output int cycles);
        @(posedge clk);
        #10;
        hold = 1'b1;
        foreach (program_q[i]) begin
            load_en = 1'b1;
            load_addr = MEM_AW'(i);
            load_data = program_q[i];
            @(posedge clk);
            #10;
        end
        foreach (data_addr_q[i]) begin
            load_en = 1'b1;
            load_addr = MEM_AW'(data_addr_q[i] >> 2);
            load_data = data_val_q[i];
            @(posedge clk);
            #10;
        end
        load_en = 1'b0;
        hold = 1'b0;
        @(negedge clk);
        while (reset) @(negedge clk);
        cycles = 0; // Now inside the first fetch cycle
        do begin
            cycles++;
            @(negedge clk);
        end while (!halted && cycles < WAIT_LIMIT);
        if (!halted) begin
            abort_run("The core did not raise halted within the wait limit");
        end
    endtask

    task automatic arith_ops(input string name, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        int cycles;
        clear_image();
        program_q.push_back(load_word_instr(1, 0, 'h200));
        program_q.push_back(load_word_instr(2, 0, 'h204));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 3, 1, 2));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b1, 4, 1, 2));
        program_q.push_back(r_type_instr(ALU_F3_AND, 1'b0, 5, 1, 2));
        program_q.push_back(r_type_instr(ALU_F3_OR, 1'b0, 6, 1, 2));
        program_q.push_back(r_type_instr(ALU_F3_SLT, 1'b0, 7, 1, 2));
        program_q.push_back(ecall_instr());
        place_data('h200, a);
        place_data('h204, b);
        run_program(cycles);
        check_cycles(name, 2 * CYC_LW + 5 * CYC_R + CYC_ECALL, cycles);
        check_reg({name, " add"}, 3, a + b);
        check_reg({name, " sub"}, 4, a - b);
        check_reg({name, " and"}, 5, a & b);
        check_reg({name, " or"}, 6, a | b);
        check_reg({name, " slt"}, 7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    endtask

    task automatic store_then_load(input string name);
        int cycles;
        logic [XLEN-1:0] value;
        value = rand_word();
        clear_image();
        program_q.push_back(load_word_instr(1, 0, 'h200));
        program_q.push_back(store_word_instr(1, 0, 'h208));
        program_q.push_back(load_word_instr(2, 0, 'h208));
        program_q.push_back(ecall_instr());
        place_data('h200, value);
        place_data('h208, ~value); // Old content differs from the stored value
        run_program(cycles);
        check_cycles(name, 2 * CYC_LW + CYC_SW + CYC_ECALL, cycles);
        check_mem(name, 'h208, value);
        check_reg(name, 2, value);
    endtask

    task automatic branch_eq(input string name, input logic taken);
        int cycles;
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        v1 = rand_word() | 32'd1;
        v2 = taken ? v1 : (v1 ^ 32'd2);
        clear_image();
        program_q.push_back(load_word_instr(1, 0, 'h200));
        program_q.push_back(load_word_instr(2, 0, 'h204));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 7, 0, 0));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 8, 0, 0));
        program_q.push_back(branch_eq_instr(1, 2, 8));           // At 0x10 with target 0x18
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 7, 1, 1));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 8, 1, 2));
        program_q.push_back(ecall_instr());
        place_data('h200, v1);
        place_data('h204, v2);
        run_program(cycles);
        check_reg(name, 7, taken ? 32'd0 : v1 + v1);
        check_reg(name, 8, v1 + v2);
        check_cycles(name, 2 * CYC_LW + (taken ? 3 : 4) * CYC_R + CYC_BEQ + CYC_ECALL, cycles);
    endtask

    task automatic cycle_count(input string name);
        int cycles;
        logic [XLEN-1:0] value;
        value = rand_word() | 32'd1;
        clear_image();
        program_q.push_back(load_word_instr(1, 0, 'h200));
        program_q.push_back(store_word_instr(1, 0, 'h20C));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 3, 1, 1));
        program_q.push_back(branch_eq_instr(1, 0, 8));           // Not taken
        program_q.push_back(branch_eq_instr(0, 0, 8));           // Taken over the next add
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 4, 1, 1));
        program_q.push_back(ecall_instr());
        place_data('h200, value);
        run_program(cycles);
        check_cycles(name, CYC_LW + CYC_SW + CYC_R + 2 * CYC_BEQ + CYC_ECALL, cycles);
        check_reg(name, 3, value + value);
    endtask

    task automatic x0_stays_zero(input string name);
        int cycles;
        logic [XLEN-1:0] value;
        value = rand_word() | 32'd1;
        clear_image();
        program_q.push_back(load_word_instr(1, 0, 'h200));
        program_q.push_back(r_type_instr(ALU_F3_ADD, 1'b0, 0, 1, 1));
        program_q.push_back(ecall_instr());
        place_data('h200, value);
        run_program(cycles);
        check_cycles(name, CYC_LW + CYC_R + CYC_ECALL, cycles);
        check_reg(name, 1, value);
        check_reg(name, 0, 32'd0);
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        hold = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_mem_addr = '0;
        dbg_reg_addr = '0;
        lfsr = LFSR_SEED;
        arith_ops("arith", 32'h0000_1234, 32'hFFFF_FF00); // Negative b for slt
        store_then_load("store_load");
        branch_eq("beq_taken", 1'b1);
        branch_eq("beq_not_taken", 1'b0);
        cycle_count("cycle_count");
        x0_stays_zero("x0_zero");
        for (int r = 0; r < 8; r++) begin
            arith_ops($sformatf("random_%0d", r), rand_word(), rand_word());
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/rv_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/unified_memory.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/multicycle_cpu.sv
sim/tb_clock_gen.sv
sim/tb_multicycle_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f filelist.f --top-module tb_multicycle_cpu -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished"
exit 0
